//--- flist.f
logic/timer_pkg.sv
logic/timer_config_regs.sv
logic/timer_prescaler.sv
logic/timer_channel.sv
logic/timer_event_collector.sv
logic/timer_bank_top.sv
tests/timer_bank_tb.sv

//--- tests/timer_bank_tb.sv
// Timer bank testbench
`timescale 1ns/1ps
`default_nettype none

module timer_bank_tb;

    import timer_pkg::*;

    localparam int clk_period   = 8;
    localparam int reset_cycles = 8;
    // Rough cycle budget per test summed into the watchdog limit
    localparam int t_count      = 60;
    localparam int t_match      = 40;
    localparam int t_overflow   = 60;
    localparam int t_prescale   = 90;
    localparam int t_stop       = 100;
    localparam int margin       = 200;
    localparam int run_cycles   = reset_cycles + t_count + t_match + t_overflow
                                  + t_prescale + t_stop + margin;

    logic                    clk;
    logic                    rst;
    logic                    cfg_wr;
    chan_idx_t               cfg_chan;
    reg_sel_t                cfg_sel;
    count_t                  cfg_wdata;
    logic [num_channels-1:0] status_clr;
    chan_idx_t               rd_chan;
    logic                    irq;
    logic [num_channels-1:0] match_flags;
    logic [num_channels-1:0] overflow_flags;
    count_t                  rd_count;

    integer    seed = 32'h8b7e2b84;
    int        errors = 0;
    int        checks = 0;
    chan_idx_t ch_a, ch_b, ch_c, ch_d;
    count_t    load_a, load_b, load_d;
    count_t    frozen, first, second;

    timer_bank_top timer_bank_top_inst (
        .clk            (clk),
        .rst            (rst),
        .cfg_wr         (cfg_wr),
        .cfg_chan       (cfg_chan),
        .cfg_sel        (cfg_sel),
        .cfg_wdata      (cfg_wdata),
        .status_clr     (status_clr),
        .rd_chan        (rd_chan),
        .irq            (irq),
        .match_flags    (match_flags),
        .overflow_flags (overflow_flags),
        .rd_count       (rd_count)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    function automatic logic [num_channels-1:0] chan_mask(input chan_idx_t ch);
        return 4'b0001 << ch;
    endfunction

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("CHECK FAILED %s: got %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic write_reg(input chan_idx_t ch, input reg_sel_t sel, input count_t data);
        @(posedge clk);
        cfg_wr    <= 1'b1;
        cfg_chan  <= ch;
        cfg_sel   <= sel;
        cfg_wdata <= data;
        @(posedge clk);
        cfg_wr    <= 1'b0;
    endtask

    task automatic select_read(input chan_idx_t ch);
        @(posedge clk);
        rd_chan <= ch;
    endtask

    // Readback is registered one edge after the select
    task automatic read_count(input chan_idx_t ch, output count_t value);
        select_read(ch);
        @(posedge clk);
        @(negedge clk);
        value = rd_count;
    endtask

    task automatic wait_count(input count_t target);
        int n;
        n = 0;
        @(negedge clk);
        while (rd_count !== target && n < 16) begin
            @(negedge clk);
            n++;
        end
        if (rd_count !== target) begin
            errors++;
            $display("Timed out waiting for rd_count to reach %h", target);
        end
    endtask

    task automatic pulse_status_clr(input logic [num_channels-1:0] mask);
        @(posedge clk);
        status_clr <= mask;
        @(posedge clk);
        status_clr <= '0;
        @(negedge clk);
    endtask

    // One tick every 4 cycles gives 4 steps per 16-cycle window
    task automatic check_prescaled(input count_t load);
        count_t samples [48];
        count_t step;
        wait_count(load);
        samples[0] = rd_count;
        for (int i = 1; i < 48; i++) begin
            @(negedge clk);
            samples[i] = rd_count;
        end
        for (int i = 0; i < 47; i++) begin
            step = samples[i+1] - samples[i];
            checks++;
            assert (step <= 16'h0001) else begin
                errors++;
                $display("CHECK FAILED rd_count step: %h -> %h", samples[i], samples[i+1]);
            end
        end
        for (int i = 0; i + 16 < 48; i++) begin
            check_value("rd_count window", samples[i+16] - samples[i], 16'h0004);
        end
    endtask

    initial begin
        rst        = 1'b1;
        cfg_wr     = 1'b0;
        cfg_chan   = '0;
        cfg_sel    = '0;
        cfg_wdata  = '0;
        status_clr = '0;
        rd_chan    = '0;
        ch_a   = chan_idx_t'($random(seed));
        ch_b   = ch_a + chan_idx_t'(1);
        ch_c   = ch_a + chan_idx_t'(2);
        ch_d   = ch_a + chan_idx_t'(3);
        load_a = (count_t'($random(seed)) & 16'h3fff) | 16'h0100;
        load_b = (count_t'($random(seed)) & 16'h3fff) | 16'h0100;
        load_d = (count_t'($random(seed)) & 16'h3fff) | 16'h0100;
        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b0;

        // Reset state
        @(negedge clk);
        check_value("irq", irq, 1'b0);
        check_value("match_flags", match_flags, 4'h0);
        check_value("overflow_flags", overflow_flags, 4'h0);
        check_value("rd_count", rd_count, 16'h0000);

        // Free counting with div 0
        select_read(ch_a);
        write_reg(ch_a, reg_load, load_a);
        write_reg(ch_a, reg_compare, load_a + 16'h8000);  // Far away
        write_reg(ch_a, reg_control, 16'h0001);
        wait_count(load_a);
        for (int k = 1; k <= 12; k++) begin
            @(negedge clk);
            check_value("rd_count", rd_count, load_a + count_t'(k));
        end
        read_count(ch_b, first);
        check_value("rd_count idle", first, 16'h0000);
        read_count(ch_c, first);
        check_value("rd_count idle", first, 16'h0000);
        read_count(ch_d, first);
        check_value("rd_count idle", first, 16'h0000);

        // Compare match at load+5
        select_read(ch_b);
        write_reg(ch_b, reg_load, load_b);
        write_reg(ch_b, reg_compare, load_b + 16'd5);
        write_reg(ch_b, reg_control, 16'h0001);
        wait_count(load_b);
        for (int k = 1; k <= 4; k++) begin
            @(negedge clk);
            check_value("rd_count", rd_count, load_b + count_t'(k));
        end
        check_value("match_flags", match_flags, 4'h0);
        repeat (2) begin  // Extra cycle held at compare
            @(negedge clk);
            check_value("rd_count", rd_count, load_b + 16'd5);
        end
        for (int k = 6; k <= 7; k++) begin
            @(negedge clk);
            check_value("rd_count", rd_count, load_b + count_t'(k));
        end
        check_value("match_flags", match_flags, chan_mask(ch_b));
        check_value("overflow_flags", overflow_flags, 4'h0);
        check_value("irq", irq, 1'b1);

        // Overflow, then match at 0
        select_read(ch_c);
        write_reg(ch_c, reg_load, 16'hfff0);
        write_reg(ch_c, reg_compare, 16'h0000);
        write_reg(ch_c, reg_control, 16'h0001);
        wait_count(16'hfff0);
        for (int k = 1; k <= 15; k++) begin
            @(negedge clk);
            check_value("rd_count", rd_count, 16'hfff0 + count_t'(k));
        end
        @(negedge clk);
        check_value("rd_count", rd_count, 16'h0000);
        check_value("overflow_flags", overflow_flags, chan_mask(ch_c));
        check_value("match_flags", match_flags, chan_mask(ch_b));
        repeat (2) begin  // Overflow state, then compare hold
            @(negedge clk);
            check_value("rd_count", rd_count, 16'h0000);
        end
        for (int k = 1; k <= 3; k++) begin
            @(negedge clk);
            check_value("rd_count", rd_count, count_t'(k));
        end
        check_value("match_flags", match_flags, chan_mask(ch_b) | chan_mask(ch_c));

        // Prescaler with div 3
        write_reg(ch_d, reg_prescale, 16'h0003);
        select_read(ch_d);
        write_reg(ch_d, reg_load, load_d);
        write_reg(ch_d, reg_compare, load_d + 16'h8000);
        write_reg(ch_d, reg_control, 16'h0001);
        check_prescaled(load_d);

        // Stop, clear and flag clearing
        select_read(ch_a);
        write_reg(ch_a, reg_control, 16'h0000);
        repeat (4) @(negedge clk);
        frozen = rd_count;
        repeat (8) begin
            @(negedge clk);
            check_value("rd_count frozen", rd_count, frozen);
        end
        write_reg(ch_a, reg_control, 16'h0002);  // Clear bit only
        wait_count(16'h0000);
        repeat (4) begin
            @(negedge clk);
            check_value("rd_count cleared", rd_count, 16'h0000);
        end
        read_count(ch_c, first);
        repeat (16) @(negedge clk);
        second = rd_count;
        check_value("rd_count other channel", second - first, 16'h0004);
        pulse_status_clr(chan_mask(ch_b));
        check_value("match_flags", match_flags, chan_mask(ch_c));
        check_value("overflow_flags", overflow_flags, chan_mask(ch_c));
        check_value("irq", irq, 1'b1);
        pulse_status_clr(chan_mask(ch_c));
        check_value("match_flags", match_flags, 4'h0);
        check_value("overflow_flags", overflow_flags, 4'h0);
        check_value("irq", irq, 1'b0);

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(run_cycles * clk_period);
        $display("Timeout: the run did not finish within %0d cycles", run_cycles);
        $display("Checks run: %0d, errors: %0d", checks, errors);
        $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- logic/timer_bank_top.sv
// Four-channel timer bank
`timescale 1ns/1ps
`default_nettype none

module timer_bank_top (
    input  wire                                clk,
    input  wire                                rst,
    input  wire                                cfg_wr,
    input  wire timer_pkg::chan_idx_t          cfg_chan,
    input  wire timer_pkg::reg_sel_t           cfg_sel,
    input  wire timer_pkg::count_t             cfg_wdata,
    input  wire [timer_pkg::num_channels-1:0]  status_clr,
    input  wire timer_pkg::chan_idx_t          rd_chan,
    output logic                               irq,
    output logic [timer_pkg::num_channels-1:0] match_flags,
    output logic [timer_pkg::num_channels-1:0] overflow_flags,
    output timer_pkg::count_t                  rd_count
);

    import timer_pkg::*;

    chan_cfg_t    chan_cfg    [num_channels];
    chan_status_t chan_status [num_channels];
    div_t         prescale_div;
    logic         tick;  // Shared by all channels

    timer_config_regs timer_config_regs_inst (
        .clk          (clk),
        .rst          (rst),
        .cfg_wr       (cfg_wr),
        .cfg_chan     (cfg_chan),
        .cfg_sel      (cfg_sel),
        .cfg_wdata    (cfg_wdata),
        .chan_cfg     (chan_cfg),
        .prescale_div (prescale_div)
    );

    timer_prescaler timer_prescaler_inst (
        .clk          (clk),
        .rst          (rst),
        .prescale_div (prescale_div),
        .tick         (tick)
    );

    for (genvar i = 0; i < num_channels; i++) begin : g_chan
        timer_channel timer_channel_inst (
            .clk    (clk),
            .rst    (rst),
            .tick   (tick),
            .cfg    (chan_cfg[i]),
            .status (chan_status[i])
        );
    end

    timer_event_collector timer_event_collector_inst (
        .clk            (clk),
        .rst            (rst),
        .chan_status    (chan_status),
        .status_clr     (status_clr),
        .rd_chan        (rd_chan),
        .irq            (irq),
        .match_flags    (match_flags),
        .overflow_flags (overflow_flags),
        .rd_count       (rd_count)
    );

endmodule

`default_nettype wire

//--- logic/timer_event_collector.sv
// Timer event flags and count readback
`timescale 1ns/1ps
`default_nettype none

module timer_event_collector (
    input  wire                                 clk,
    input  wire                                 rst,
    input  wire timer_pkg::chan_status_t        chan_status [timer_pkg::num_channels],
    input  wire [timer_pkg::num_channels-1:0]   status_clr,
    input  wire timer_pkg::chan_idx_t           rd_chan,
    output logic                                irq,
    output logic [timer_pkg::num_channels-1:0]  match_flags,
    output logic [timer_pkg::num_channels-1:0]  overflow_flags,
    output timer_pkg::count_t                   rd_count
);

    import timer_pkg::*;

    logic [num_channels-1:0] match_pulse;
    logic [num_channels-1:0] overflow_pulse;

    // Gather the pulses into vectors
    always_comb begin
        for (int i = 0; i < num_channels; i++) begin
            match_pulse[i]    = chan_status[i].match_pulse;
            overflow_pulse[i] = chan_status[i].overflow_pulse;
        end
    end

    // Sticky flags, a new pulse beats a clear in the same cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            match_flags    <= '0;
            overflow_flags <= '0;
        end else begin
            match_flags    <= match_pulse | (match_flags & ~status_clr);
            overflow_flags <= overflow_pulse | (overflow_flags & ~status_clr);
        end
    end

    assign irq = |{match_flags, overflow_flags};

    // Readback of the selected channel
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_count <= '0;
        end else begin
            rd_count <= chan_status[rd_chan].count;
        end
    end

endmodule

`default_nettype wire

//--- logic/timer_channel.sv
// Timer channel with compare and overflow
`timescale 1ns/1ps
`default_nettype none

module timer_channel (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       tick,
    input  wire timer_pkg::chan_cfg_t cfg,
    output timer_pkg::chan_status_t   status
);

    import timer_pkg::*;

    chan_state_t state_q;
    count_t      counter_q;
    count_t      count_q;
    logic        enable_d;
    logic        enable_rise;
    logic        match_q;
    logic        overflow_q;
    logic        active_q;

    assign enable_rise = cfg.enable && !enable_d;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q    <= idle;
            counter_q  <= '0;
            enable_d   <= 1'b0;
            match_q    <= 1'b0;
            overflow_q <= 1'b0;
            active_q   <= 1'b0;
        end else begin
            enable_d   <= cfg.enable;
            match_q    <= 1'b0;  // Pulses last one cycle
            overflow_q <= 1'b0;

            case (state_q)
                idle: begin
                    active_q <= 1'b0;
                    if (enable_rise) begin
                        counter_q <= cfg.load;
                        state_q   <= running;
                        active_q  <= 1'b1;
                    end else if (cfg.clear) begin
                        counter_q <= '0;
                    end
                end

                running: begin
                    if (cfg.clear || !cfg.enable) begin
                        state_q  <= idle;
                        active_q <= 1'b0;
                    end else if (tick) begin
                        // Compare checked first so it wins over wrap
                        if (counter_q == cfg.compare) begin
                            match_q <= 1'b1;
                            state_q <= match;
                        end else if (counter_q == '1) begin
                            counter_q  <= '0;
                            overflow_q <= 1'b1;
                            state_q    <= overflow;
                        end else begin
                            counter_q <= counter_q + 1'b1;
                        end
                    end
                end

                overflow: begin
                    if (cfg.enable && !cfg.clear) begin
                        state_q <= running;
                    end else begin
                        state_q  <= idle;
                        active_q <= 1'b0;
                    end
                end

                match: begin
                    // Held one cycle at compare, now step on
                    if (cfg.enable && !cfg.clear) begin
                        counter_q <= counter_q + 1'b1;
                        state_q   <= running;
                    end else begin
                        state_q  <= idle;
                        active_q <= 1'b0;
                    end
                end

                default: state_q <= idle;
            endcase
        end
    end

    // Count output lags the counter by one cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count_q <= '0;
        end else begin
            count_q <= counter_q;
        end
    end

    always_comb begin
        status.count          = count_q;
        status.overflow_pulse = overflow_q;
        status.match_pulse    = match_q;
        status.active         = active_q;
    end

endmodule

`default_nettype wire

//--- logic/timer_prescaler.sv
// Shared programmable prescaler
`timescale 1ns/1ps
`default_nettype none

module timer_prescaler (
    input  wire                  clk,
    input  wire                  rst,
    input  wire timer_pkg::div_t prescale_div,
    output logic                 tick
);

    import timer_pkg::*;

    div_t cnt_q;
    div_t div_q;     // Divisor the current phase runs on
    logic div_change;

    assign div_change = (prescale_div != div_q);

    // Down-counter, reloads at zero
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt_q <= '0;
            div_q <= '0;
        end else if (div_change) begin
            // New divisor restarts the phase
            cnt_q <= prescale_div;
            div_q <= prescale_div;
        end else if (cnt_q == '0) begin
            cnt_q <= div_q;
        end else begin
            cnt_q <= cnt_q - 1'b1;
        end
    end

    // High every cycle when the divisor is 0
    assign tick = (cnt_q == '0) && !div_change;

endmodule

`default_nettype wire

//--- logic/timer_config_regs.sv
// Timer bank configuration registers
`timescale 1ns/1ps
`default_nettype none

module timer_config_regs (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       cfg_wr,
    input  wire timer_pkg::chan_idx_t cfg_chan,
    input  wire timer_pkg::reg_sel_t  cfg_sel,
    input  wire timer_pkg::count_t    cfg_wdata,
    output timer_pkg::chan_cfg_t      chan_cfg [timer_pkg::num_channels],
    output timer_pkg::div_t           prescale_div
);

    import timer_pkg::*;

    count_t                  load_q    [num_channels];
    count_t                  compare_q [num_channels];
    logic [num_channels-1:0] enable_q;
    logic [num_channels-1:0] clear_q;
    logic [num_channels-1:0] chan_hit;
    div_t                    div_q;

    // One-hot decode of the addressed channel
    always_comb begin
        for (int i = 0; i < num_channels; i++) begin
            chan_hit[i] = cfg_wr && (cfg_chan == chan_idx_t'(i));
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < num_channels; i++) begin
                load_q[i]    <= '0;
                compare_q[i] <= '0;
            end
            enable_q <= '0;
            clear_q  <= '0;
        end else begin
            for (int i = 0; i < num_channels; i++) begin
                // Clear drops after one cycle unless rewritten
                clear_q[i] <= chan_hit[i] && (cfg_sel == reg_control) && cfg_wdata[1];
                if (chan_hit[i]) begin
                    case (cfg_sel)
                        reg_load:    load_q[i]    <= cfg_wdata;
                        reg_compare: compare_q[i] <= cfg_wdata;
                        reg_control: enable_q[i]  <= cfg_wdata[0];
                        default: ;  // Prescale handled below
                    endcase
                end
            end
        end
    end

    // Shared divisor
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            div_q <= '0;
        end else if (cfg_wr && (cfg_sel == reg_prescale)) begin
            div_q <= cfg_wdata[7:0];
        end
    end

    always_comb begin
        for (int i = 0; i < num_channels; i++) begin
            chan_cfg[i].load    = load_q[i];
            chan_cfg[i].compare = compare_q[i];
            chan_cfg[i].enable  = enable_q[i];
            chan_cfg[i].clear   = clear_q[i];
        end
    end

    assign prescale_div = div_q;

endmodule

`default_nettype wire

//--- logic/timer_pkg.sv
// Timer bank shared types and constants
`default_nettype none

package timer_pkg;

    localparam int num_channels = 4;

    // Count, load and compare values
    typedef logic [15:0] count_t;

    // Prescale divisor, one tick every div+1 cycles
    typedef logic [7:0] div_t;

    typedef logic [1:0] chan_idx_t;
    typedef logic [1:0] reg_sel_t;

    // Register select codes
    localparam reg_sel_t reg_load     = 2'd0;
    localparam reg_sel_t reg_compare  = 2'd1;
    localparam reg_sel_t reg_control  = 2'd2; // Bit 0 enable, bit 1 clear
    localparam reg_sel_t reg_prescale = 2'd3; // Global, channel ignored

    // Channel counter FSM
    typedef enum logic [1:0] {
        idle     = 2'd0,
        running  = 2'd1,
        overflow = 2'd2,
        match    = 2'd3
    } chan_state_t;

    // Per-channel configuration, 34 bits
    typedef struct packed {
        count_t load;
        count_t compare;
        logic   enable;  // Level
        logic   clear;   // One-cycle pulse
    } chan_cfg_t;

    // Per-channel status, 19 bits
    typedef struct packed {
        count_t count;
        logic   overflow_pulse;
        logic   match_pulse;
        logic   active;
    } chan_status_t;

endpackage

`default_nettype wire
